// File: all.f
+incdir+.
decode_pkg.sv
inst_queue.sv
inst_decoder.sv
dispatch_reg.sv
decode_stage.sv
decode_checker.sv
tb_decode_stage.sv

// File: Bender.yml
package:
  name: decode_stage

sources:
  - target: rtl
    include_dirs:
      - .
    files:
      - decode_pkg.sv
      - inst_queue.sv
      - inst_decoder.sv
      - dispatch_reg.sv
      - decode_stage.sv
  - target: test
    include_dirs:
      - .
    files:
      - decode_checker.sv
      - tb_decode_stage.sv

// File: tb_decode_stage.sv
//////////////////////////////////////////////////
// decode stage testbench
// table-driven fetch stream, random back-pressure,
// fill, flush and first-word latency tests
//////////////////////////////////////////////////

`default_nettype none

`include "rv32_fields.svh"

module tb_decode_stage;
	import decode_pkg::*;

	localparam int queue_depth = 4;

	typedef struct packed {
		logic [xlen-1:0] inst;
		logic [xlen-1:0] pc;
		fu_type_e        fu;
		alu_func_e       alu;
		reg_idx_t        src1;
		reg_idx_t        src2;
		reg_idx_t        dest;
		logic [xlen-1:0] imm;
		imm_sel_e        sel;
		logic            csr;
		logic            halt;
		logic            ill;
	} row_t;

	logic            clock = 1'b0;
	logic            rst_n;
	logic            flush;
	logic            in_valid;
	logic            out_ready;
	row_t            cur;
	row_t            rows[$];
	logic            in_ready;
	logic            out_valid;
	logic [xlen-1:0] out_pc;
	fu_type_e        out_fu;
	alu_func_e       out_alu_func;
	reg_idx_t        out_src1;
	reg_idx_t        out_src2;
	reg_idx_t        out_dest;
	logic [xlen-1:0] out_imm;
	imm_sel_e        out_imm_sel;
	logic            out_csr_op;
	logic            out_halt;
	logic            illegal;
	int              chk_errors;
	int              pending;
	int              tb_errors = 0;
	integer          seed = 32'hfadd6e3c;
	int              rnd;
	logic            ready_random = 1'b0;
	logic            ready_level = 1'b1;

	always #20 clock = ~clock;

	decode_stage #(
		.QUEUE_DEPTH(queue_depth)
	) uut (
		.clock(clock), .rst_n(rst_n), .flush(flush),
		.in_valid(in_valid), .in_inst(cur.inst), .in_pc(cur.pc), .in_ready(in_ready),
		.out_valid(out_valid), .out_ready(out_ready), .out_pc(out_pc), .out_fu(out_fu),
		.out_alu_func(out_alu_func), .out_src1(out_src1), .out_src2(out_src2),
		.out_dest(out_dest), .out_imm(out_imm), .out_imm_sel(out_imm_sel),
		.out_csr_op(out_csr_op), .out_halt(out_halt), .illegal(illegal)
	);

	decode_checker chk (
		.clock(clock), .rst_n(rst_n), .flush(flush),
		.in_valid(in_valid), .in_ready(in_ready), .in_pc(cur.pc),
		.exp_fu(cur.fu), .exp_alu_func(cur.alu), .exp_src1(cur.src1), .exp_src2(cur.src2),
		.exp_dest(cur.dest), .exp_imm(cur.imm), .exp_imm_sel(cur.sel),
		.exp_csr_op(cur.csr), .exp_halt(cur.halt), .exp_illegal(cur.ill),
		.out_valid(out_valid), .out_ready(out_ready), .out_pc(out_pc), .out_fu(out_fu),
		.out_alu_func(out_alu_func), .out_src1(out_src1), .out_src2(out_src2),
		.out_dest(out_dest), .out_imm(out_imm), .out_imm_sel(out_imm_sel),
		.out_csr_op(out_csr_op), .out_halt(out_halt), .illegal(illegal),
		.errors(chk_errors), .pending(pending)
	);

	// consumer drives a random or a held ready level
	always @(posedge clock) begin
		#2;
		rnd = $random(seed);
		if (ready_random)
			out_ready = rnd[0];
		else
			out_ready = ready_level;
	end

	// instruction encoders taking immediates as plain values
	function automatic logic [31:0] enc_r(input logic [6:0] f7, input int rs2,
			input int rs1, input logic [2:0] f3, input int rd);
		return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OP_OP};
	endfunction

	function automatic logic [31:0] enc_i(input int imm, input int rs1,
			input logic [2:0] f3, input int rd, input logic [6:0] op);
		return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
	endfunction

	function automatic logic [31:0] enc_s(input int imm, input int rs2, input int rs1,
			input logic [2:0] f3);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], OP_STORE};
	endfunction

	function automatic logic [31:0] enc_b(input int imm, input int rs2, input int rs1,
			input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], OP_BRANCH};
	endfunction

	function automatic logic [31:0] enc_u(input int imm, input int rd, input logic [6:0] op);
		return {imm[31:12], rd[4:0], op};
	endfunction

	function automatic logic [31:0] enc_j(input int imm, input int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OP_JAL};
	endfunction

	task automatic put_row(input logic [31:0] inst, input fu_type_e fu, input alu_func_e alu,
			input int s1, input int s2, input int d, input imm_sel_e sel, input int imm,
			input logic [2:0] flags);
		row_t r;
		r.inst = inst;
		// one word aligned pc per row
		r.pc   = 32'h0000_1000 + 4 * rows.size();
		r.fu   = fu;
		r.alu  = alu;
		r.src1 = s1[4:0];
		r.src2 = s2[4:0];
		r.dest = d[4:0];
		r.imm  = imm;
		r.sel  = sel;
		{r.csr, r.halt, r.ill} = flags;
		rows.push_back(r);
	endtask

	task automatic add_row(input logic [31:0] inst, input fu_type_e fu, input alu_func_e alu,
			input int s1, input int s2, input int d, input imm_sel_e sel, input int imm);
		put_row(inst, fu, alu, s1, s2, d, sel, imm, 3'b000);
	endtask

	// csr, halt or illegal word with every other field at default
	task automatic add_flagged(input logic [31:0] inst, input logic csr, input logic halt,
			input logic ill);
		put_row(inst, FU_ALU, ALU_ADD, 0, 0, 0, IMM_NONE, 0, {csr, halt, ill});
	endtask

	task automatic build_table();
		// the first six rows are legal for the fill test
		add_row(enc_r(`F7_BASE, 2, 1, `F3_ADD, 3), FU_ALU, ALU_ADD, 1, 2, 3, IMM_NONE, 0);
		add_row(enc_r(`F7_ALT, 7, 6, `F3_ADD, 5), FU_ALU, ALU_SUB, 6, 7, 5, IMM_NONE, 0);
		add_row(enc_r(`F7_BASE, 10, 9, `F3_AND, 8), FU_ALU, ALU_AND, 9, 10, 8, IMM_NONE, 0);
		add_row(enc_r(`F7_ALT, 13, 12, `F3_SR, 11), FU_ALU, ALU_SRA, 12, 13, 11, IMM_NONE, 0);
		add_row(enc_r(`F7_MULDIV, 16, 15, `F3_MULHSU, 14),
			FU_MULT, ALU_MULHSU, 15, 16, 14, IMM_NONE, 0);
		add_row(enc_r(`F7_MULDIV, 19, 18, `F3_MUL, 17),
			FU_MULT, ALU_MUL, 18, 19, 17, IMM_NONE, 0);
		add_row(enc_i(-5, 2, `F3_ADD, 1, OP_OP_IMM), FU_ALU, ALU_ADD, 2, 0, 1, IMM_I, -5);
		add_row(enc_i(7, 5, `F3_SR, 4, OP_OP_IMM), FU_ALU, ALU_SRL, 5, 0, 4, IMM_I, 7);
		// unknown major opcode
		add_flagged(32'h0000_007f, 1'b0, 1'b0, 1'b1);
		add_row(enc_i(-16, 7, `F3_LW, 6, OP_LOAD), FU_MEM, ALU_ADD, 7, 0, 6, IMM_I, -16);
		add_row(enc_s(2044, 8, 9, `F3_LW), FU_MEM, ALU_ADD, 9, 8, 0, IMM_S, 2044);
		add_row(enc_b(-12, 2, 1, `F3_BNE), FU_BRANCH, ALU_ADD, 1, 2, 0, IMM_B, -12);
		add_row(enc_u(32'habcde000, 10, OP_LUI),
			FU_ALU, ALU_ADD, 0, 0, 10, IMM_U, 32'habcde000);
		add_flagged(enc_i('h300, 3, `F3_CSRRW, 2, OP_SYSTEM), 1'b1, 1'b0, 1'b0);
		// sll with the alternate funct7
		add_flagged(enc_r(`F7_ALT, 1, 2, `F3_SLL, 3), 1'b0, 1'b0, 1'b1);
		add_row(enc_u(32'h00012000, 11, OP_AUIPC),
			FU_ALU, ALU_ADD, 0, 0, 11, IMM_U, 32'h00012000);
		add_row(enc_j(-2048, 1), FU_BRANCH, ALU_ADD, 0, 0, 1, IMM_J, -2048);
		add_flagged(`RV32_WFI, 1'b0, 1'b1, 1'b0);
		add_row(enc_i(100, 6, 3'b000, 5, OP_JALR), FU_BRANCH, ALU_ADD, 6, 0, 5, IMM_I, 100);
		// divu is not implemented
		add_flagged(enc_r(`F7_MULDIV, 1, 2, 3'b101, 3), 1'b0, 1'b0, 1'b1);
		add_row(enc_b(2000, 4, 3, `F3_BGEU), FU_BRANCH, ALU_ADD, 3, 4, 0, IMM_B, 2000);
		add_row(enc_i(-1, 10, `F3_SLTU, 9, OP_OP_IMM), FU_ALU, ALU_SLTU, 10, 0, 9, IMM_I, -1);
		add_flagged(enc_i('hc00, 0, `F3_CSRRS, 7, OP_SYSTEM), 1'b1, 1'b0, 1'b0);
	endtask

	task automatic check_level(input string what, input logic have, input logic want);
		if (have !== want) begin
			$display("MISMATCH at %0t: %s is %b, expected %b", $time, what, have, want);
			tb_errors++;
		end
	endtask

	// takes effect after the ready driver has run in this step
	task automatic set_ready(input logic level);
		ready_random <= 1'b0;
		ready_level  <= level;
		out_ready    <= level;
	endtask

	// hold one row on the fetch side until the queue takes it
	task automatic send_row(input int r);
		logic accepted;
		cur = rows[r];
		in_valid = 1'b1;
		do begin
			accepted = in_ready;
			@(posedge clock);
			#2;
		end while (!accepted);
		in_valid = 1'b0;
	endtask

	task automatic send_range(input int first, input int last);
		for (int r = first; r <= last; r++)
			send_row(r);
	endtask

	task automatic wait_idle();
		set_ready(1'b1);
		do begin
			@(posedge clock);
			#2;
		end while (pending != 0 || out_valid);
	endtask

	initial begin
		build_table();
		rst_n = 1'b0;
		flush = 1'b0;
		in_valid = 1'b0;
		cur = '0;
		out_ready = 1'b1;
		repeat (8) @(posedge clock);
		#2;
		rst_n = 1'b1;
		check_level("in_ready after reset", in_ready, 1'b1);
		check_level("out_valid after reset", out_valid, 1'b0);
		check_level("illegal after reset", illegal, 1'b0);

		// on an empty stage a word shows two edges after it is presented
		cur = rows[0];
		in_valid = 1'b1;
		@(posedge clock);
		#2;
		in_valid = 1'b0;
		check_level("out_valid one edge after accept", out_valid, 1'b0);
		@(posedge clock);
		#2;
		check_level("out_valid two edges after accept", out_valid, 1'b1);
		wait_idle();

		// every class under random back-pressure
		ready_random <= 1'b1;
		send_range(0, rows.size() - 1);
		wait_idle();

		// stalled consumer lets the dispatch reg and the queue fill up
		set_ready(1'b0);
		send_range(0, queue_depth);
		check_level("in_ready with queue full", in_ready, 1'b0);
		repeat (3) @(posedge clock);
		#2;
		check_level("in_ready while stalled", in_ready, 1'b0);
		ready_random <= 1'b1;
		send_row(queue_depth + 1);
		wait_idle();

		// flush in mid-stream then later rows must still come out
		ready_random <= 1'b1;
		send_range(6, 11);
		flush = 1'b1;
		@(posedge clock);
		#2;
		flush = 1'b0;
		check_level("out_valid after flush", out_valid, 1'b0);
		send_range(12, rows.size() - 1);
		wait_idle();

		$display("errors: %0d from the checker, %0d from the testbench", chk_errors, tb_errors);
		if (chk_errors == 0 && tb_errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	// watchdog scaled to the table length
	initial begin
		#1;
		repeat (rows.size() * 20 + 200) @(posedge clock);
		$display("timeout: run did not finish in %0d clock periods", rows.size() * 20 + 200);
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: decode_checker.sv
//////////////////////////////////////////////////
// decode stage checker
// tracks accepted words in order and compares
// every dispatch transfer and illegal pulse
//////////////////////////////////////////////////

`default_nettype none

module decode_checker (
	input  wire logic                        clock,
	input  wire logic                        rst_n,
	input  wire logic                        flush,
	input  wire logic                        in_valid,
	input  wire logic                        in_ready,
	input  wire logic [decode_pkg::xlen-1:0] in_pc,
	input  wire decode_pkg::fu_type_e        exp_fu,
	input  wire decode_pkg::alu_func_e       exp_alu_func,
	input  wire decode_pkg::reg_idx_t        exp_src1,
	input  wire decode_pkg::reg_idx_t        exp_src2,
	input  wire decode_pkg::reg_idx_t        exp_dest,
	input  wire logic [decode_pkg::xlen-1:0] exp_imm,
	input  wire decode_pkg::imm_sel_e        exp_imm_sel,
	input  wire logic                        exp_csr_op,
	input  wire logic                        exp_halt,
	input  wire logic                        exp_illegal,
	input  wire logic                        out_valid,
	input  wire logic                        out_ready,
	input  wire logic [decode_pkg::xlen-1:0] out_pc,
	input  wire decode_pkg::fu_type_e        out_fu,
	input  wire decode_pkg::alu_func_e       out_alu_func,
	input  wire decode_pkg::reg_idx_t        out_src1,
	input  wire decode_pkg::reg_idx_t        out_src2,
	input  wire decode_pkg::reg_idx_t        out_dest,
	input  wire logic [decode_pkg::xlen-1:0] out_imm,
	input  wire decode_pkg::imm_sel_e        out_imm_sel,
	input  wire logic                        out_csr_op,
	input  wire logic                        out_halt,
	input  wire logic                        illegal,
	output int                               errors,
	output int                               pending
);
	import decode_pkg::*;

	typedef struct packed {
		logic [xlen-1:0] pc;
		fu_type_e        fu;
		alu_func_e       alu;
		reg_idx_t        src1;
		reg_idx_t        src2;
		reg_idx_t        dest;
		logic [xlen-1:0] imm;
		imm_sel_e        sel;
		logic            csr;
		logic            halt;
		logic            ill;
	} entry_t;

	// words accepted but not yet dispatched or dropped
	entry_t exp_q[$];
	entry_t got;
	entry_t snap;
	entry_t incoming;
	logic   stalled = 1'b0;
	// a legal entry sits in the dispatch register
	logic   held;
	int     count = 0;
	int     depth = 0;

	assign errors  = count;
	assign pending = depth;

	task automatic compare_field(input string name, input logic [31:0] have,
			input logic [31:0] want);
		if (have !== want) begin
			$display("MISMATCH at %0t: pc %h %s is %h, expected %h",
				$time, got.pc, name, have, want);
			count++;
		end
	endtask

	task automatic check_transfer();
		entry_t want;
		if (exp_q.size() == 0) begin
			$display("%0t: unexpected output at pc %h, nothing was pending", $time, got.pc);
			count++;
		end else begin
			want = exp_q.pop_front();
			if (want.ill) begin
				$display("%0t: pc %h came out while illegal word at pc %h was due first",
					$time, got.pc, want.pc);
				count++;
			end else begin
				compare_field("pc", got.pc, want.pc);
				compare_field("fu", got.fu, want.fu);
				compare_field("alu_func", got.alu, want.alu);
				compare_field("src1", got.src1, want.src1);
				compare_field("src2", got.src2, want.src2);
				compare_field("dest", got.dest, want.dest);
				compare_field("imm", got.imm, want.imm);
				compare_field("imm_sel", got.sel, want.sel);
				compare_field("csr_op", got.csr, want.csr);
				compare_field("halt", got.halt, want.halt);
			end
		end
	endtask

	// the pulse may overtake the stalled legal entry ahead of it
	task automatic check_pulse();
		int idx;
		idx = held ? 1 : 0;
		if (exp_q.size() > idx && exp_q[idx].ill) begin
			exp_q.delete(idx);
		end else begin
			$display("%0t: illegal pulse with no illegal word pending", $time);
			count++;
		end
	endtask

	always @(posedge clock) begin
		if (!rst_n) begin
			exp_q.delete();
			stalled = 1'b0;
			depth = 0;
		end else begin
			got.pc   = out_pc;
			got.fu   = out_fu;
			got.alu  = out_alu_func;
			got.src1 = out_src1;
			got.src2 = out_src2;
			got.dest = out_dest;
			got.imm  = out_imm;
			got.sel  = out_imm_sel;
			got.csr  = out_csr_op;
			got.halt = out_halt;
			got.ill  = 1'b0;
			// stalled entry must not move
			if (stalled && out_valid && got !== snap) begin
				$display("MISMATCH at %0t: outputs changed while stalled at pc %h",
					$time, snap.pc);
				count++;
			end
			held = out_valid && !out_ready;
			// transfer first, its word is older than any pulse here
			if (out_valid && out_ready)
				check_transfer();
			if (illegal)
				check_pulse();
			stalled = held;
			snap = got;
			// flush beats a push on the same edge
			if (flush) begin
				exp_q.delete();
			end else if (in_valid && in_ready) begin
				incoming.pc   = in_pc;
				incoming.fu   = exp_fu;
				incoming.alu  = exp_alu_func;
				incoming.src1 = exp_src1;
				incoming.src2 = exp_src2;
				incoming.dest = exp_dest;
				incoming.imm  = exp_imm;
				incoming.sel  = exp_imm_sel;
				incoming.csr  = exp_csr_op;
				incoming.halt = exp_halt;
				incoming.ill  = exp_illegal;
				exp_q.push_back(incoming);
			end
			depth = exp_q.size();
		end
	end

endmodule

`default_nettype wire

// File: decode_stage.sv
//////////////////////////////////////////////////
// decode stage top
// queue, decoder and dispatch register
//////////////////////////////////////////////////

`default_nettype none

module decode_stage #(
	// power of two
	parameter int QUEUE_DEPTH = 4
) (
	input  wire logic                        clock,
	input  wire logic                        rst_n,
	input  wire logic                        flush,
	input  wire logic                        in_valid,
	input  wire logic [decode_pkg::xlen-1:0] in_inst,
	input  wire logic [decode_pkg::xlen-1:0] in_pc,
	output logic                             in_ready,
	output logic                             out_valid,
	input  wire logic                        out_ready,
	output logic [decode_pkg::xlen-1:0]      out_pc,
	output decode_pkg::fu_type_e             out_fu,
	output decode_pkg::alu_func_e            out_alu_func,
	output decode_pkg::reg_idx_t             out_src1,
	output decode_pkg::reg_idx_t             out_src2,
	output decode_pkg::reg_idx_t             out_dest,
	output logic [decode_pkg::xlen-1:0]      out_imm,
	output decode_pkg::imm_sel_e             out_imm_sel,
	output logic                             out_csr_op,
	output logic                             out_halt,
	output logic                             illegal
);
	import decode_pkg::*;

	// queue head
	logic            head_valid;
	logic [xlen-1:0] head_inst;
	logic [xlen-1:0] head_pc;
	logic            take;

	// decoded head
	fu_type_e        dec_fu;
	alu_func_e       dec_alu_func;
	reg_idx_t        dec_src1;
	reg_idx_t        dec_src2;
	reg_idx_t        dec_dest;
	logic [xlen-1:0] dec_imm;
	imm_sel_e        dec_imm_sel;
	logic            dec_csr_op;
	logic            dec_halt;
	logic            dec_illegal;

	inst_queue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) u_queue (
		.clock      (clock),
		.rst_n      (rst_n),
		.flush      (flush),
		.in_valid   (in_valid),
		.in_inst    (in_inst),
		.in_pc      (in_pc),
		.in_ready   (in_ready),
		.take       (take),
		.head_valid (head_valid),
		.head_inst  (head_inst),
		.head_pc    (head_pc)
	);

	inst_decoder u_decoder (
		.head_valid   (head_valid),
		.head_inst    (head_inst),
		.head_pc      (head_pc),
		.dec_fu       (dec_fu),
		.dec_alu_func (dec_alu_func),
		.dec_src1     (dec_src1),
		.dec_src2     (dec_src2),
		.dec_dest     (dec_dest),
		.dec_imm      (dec_imm),
		.dec_imm_sel  (dec_imm_sel),
		.dec_csr_op   (dec_csr_op),
		.dec_halt     (dec_halt),
		.dec_illegal  (dec_illegal)
	);

	dispatch_reg u_dispatch (
		.clock        (clock),
		.rst_n        (rst_n),
		.flush        (flush),
		.head_valid   (head_valid),
		.head_pc      (head_pc),
		.dec_fu       (dec_fu),
		.dec_alu_func (dec_alu_func),
		.dec_src1     (dec_src1),
		.dec_src2     (dec_src2),
		.dec_dest     (dec_dest),
		.dec_imm      (dec_imm),
		.dec_imm_sel  (dec_imm_sel),
		.dec_csr_op   (dec_csr_op),
		.dec_halt     (dec_halt),
		.dec_illegal  (dec_illegal),
		.take         (take),
		.out_valid    (out_valid),
		.out_ready    (out_ready),
		.out_pc       (out_pc),
		.out_fu       (out_fu),
		.out_alu_func (out_alu_func),
		.out_src1     (out_src1),
		.out_src2     (out_src2),
		.out_dest     (out_dest),
		.out_imm      (out_imm),
		.out_imm_sel  (out_imm_sel),
		.out_csr_op   (out_csr_op),
		.out_halt     (out_halt),
		.illegal      (illegal)
	);

endmodule

`default_nettype wire

// File: dispatch_reg.sv
//////////////////////////////////////////////////
// dispatch register
// one decoded entry toward rename, valid/ready
//////////////////////////////////////////////////

`default_nettype none

module dispatch_reg (
	input  wire logic                        clock,
	input  wire logic                        rst_n,
	input  wire logic                        flush,
	input  wire logic                        head_valid,
	input  wire logic [decode_pkg::xlen-1:0] head_pc,
	input  wire decode_pkg::fu_type_e        dec_fu,
	input  wire decode_pkg::alu_func_e       dec_alu_func,
	input  wire decode_pkg::reg_idx_t        dec_src1,
	input  wire decode_pkg::reg_idx_t        dec_src2,
	input  wire decode_pkg::reg_idx_t        dec_dest,
	input  wire logic [decode_pkg::xlen-1:0] dec_imm,
	input  wire decode_pkg::imm_sel_e        dec_imm_sel,
	input  wire logic                        dec_csr_op,
	input  wire logic                        dec_halt,
	input  wire logic                        dec_illegal,
	output logic                             take,
	output logic                             out_valid,
	input  wire logic                        out_ready,
	output logic [decode_pkg::xlen-1:0]      out_pc,
	output decode_pkg::fu_type_e             out_fu,
	output decode_pkg::alu_func_e            out_alu_func,
	output decode_pkg::reg_idx_t             out_src1,
	output decode_pkg::reg_idx_t             out_src2,
	output decode_pkg::reg_idx_t             out_dest,
	output logic [decode_pkg::xlen-1:0]      out_imm,
	output decode_pkg::imm_sel_e             out_imm_sel,
	output logic                             out_csr_op,
	output logic                             out_halt,
	output logic                             illegal
);
	logic load;
	logic drop;

	// illegal heads are popped regardless of back-pressure
	assign take = !out_valid || out_ready || dec_illegal;
	assign load = head_valid && take && !dec_illegal;
	assign drop = head_valid && take && dec_illegal;

	// payload
	always_ff @(posedge clock) begin
		if (load && !flush) begin
			out_pc       <= head_pc;
			out_fu       <= dec_fu;
			out_alu_func <= dec_alu_func;
			out_src1     <= dec_src1;
			out_src2     <= dec_src2;
			out_dest     <= dec_dest;
			out_imm      <= dec_imm;
			out_imm_sel  <= dec_imm_sel;
			out_csr_op   <= dec_csr_op;
			out_halt     <= dec_halt;
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			illegal   <= 1'b0;
		end else if (flush) begin
			out_valid <= 1'b0;
			illegal   <= 1'b0;
		end else begin
			// one-cycle pulse per dropped word
			illegal <= drop;
			if (load)
				out_valid <= 1'b1;
			else if (out_ready)
				out_valid <= 1'b0;
		end
	end

	// stalled entry must not change under the consumer
	a_hold_stalled: assert property (@(posedge clock) disable iff (!rst_n)
		out_valid && !out_ready |=> $stable(out_pc) && $stable(out_dest));

endmodule

`default_nettype wire

// File: inst_decoder.sv
//////////////////////////////////////////////////
// instruction decoder
// combinational rv32im decode of the queue head
//////////////////////////////////////////////////

`default_nettype none

`include "rv32_fields.svh"

module inst_decoder (
	input  wire logic                      head_valid,
	input  wire logic [decode_pkg::xlen-1:0] head_inst,
	input  wire logic [decode_pkg::xlen-1:0] head_pc,
	output decode_pkg::fu_type_e           dec_fu,
	output decode_pkg::alu_func_e          dec_alu_func,
	output decode_pkg::reg_idx_t           dec_src1,
	output decode_pkg::reg_idx_t           dec_src2,
	output decode_pkg::reg_idx_t           dec_dest,
	output logic [decode_pkg::xlen-1:0]    dec_imm,
	output decode_pkg::imm_sel_e           dec_imm_sel,
	output logic                           dec_csr_op,
	output logic                           dec_halt,
	output logic                           dec_illegal
);
	import decode_pkg::*;

	opcode_e    opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	reg_idx_t   rd;
	reg_idx_t   rs1;
	reg_idx_t   rs2;

	// raw fields, r-type positions
	assign opcode = opcode_e'(head_inst[6:0]);
	assign rd     = head_inst[11:7];
	assign funct3 = head_inst[14:12];
	assign rs1    = head_inst[19:15];
	assign rs2    = head_inst[24:20];
	assign funct7 = head_inst[31:25];

	always_comb begin
		// defaults behave as a nop
		dec_fu       = FU_ALU;
		dec_alu_func = ALU_ADD;
		dec_src1     = '0;
		dec_src2     = '0;
		dec_dest     = '0;
		dec_imm      = '0;
		dec_imm_sel  = IMM_NONE;
		dec_csr_op   = 1'b0;
		dec_halt     = 1'b0;
		dec_illegal  = 1'b0;

		if (head_valid) begin
			case (opcode)
				OP_LUI, OP_AUIPC: begin
					dec_dest    = rd;
					dec_imm     = `RV32_signext_Uimm(head_inst);
					dec_imm_sel = IMM_U;
				end
				OP_JAL: begin
					dec_fu      = FU_BRANCH;
					dec_dest    = rd;
					dec_imm     = `RV32_signext_Jimm(head_inst);
					dec_imm_sel = IMM_J;
				end
				OP_JALR: begin
					dec_fu      = FU_BRANCH;
					dec_src1    = rs1;
					dec_dest    = rd;
					dec_imm     = `RV32_signext_Iimm(head_inst);
					dec_imm_sel = IMM_I;
					dec_illegal = (funct3 != 3'b000);
				end
				OP_BRANCH: begin
					dec_fu      = FU_BRANCH;
					dec_src1    = rs1;
					dec_src2    = rs2;
					dec_imm     = `RV32_signext_Bimm(head_inst);
					dec_imm_sel = IMM_B;
					// funct3 010 and 011 are unassigned
					dec_illegal = (funct3 == 3'b010) || (funct3 == 3'b011);
				end
				OP_LOAD: begin
					dec_fu      = FU_MEM;
					dec_src1    = rs1;
					dec_dest    = rd;
					dec_imm     = `RV32_signext_Iimm(head_inst);
					dec_imm_sel = IMM_I;
					dec_illegal = !(funct3 inside {`F3_LB, `F3_LH, `F3_LW, `F3_LBU, `F3_LHU});
				end
				OP_STORE: begin
					dec_fu      = FU_MEM;
					dec_src1    = rs1;
					dec_src2    = rs2;
					dec_imm     = `RV32_signext_Simm(head_inst);
					dec_imm_sel = IMM_S;
					dec_illegal = !(funct3 inside {`F3_LB, `F3_LH, `F3_LW});
				end
				OP_OP_IMM: begin
					dec_src1    = rs1;
					dec_dest    = rd;
					dec_imm     = `RV32_signext_Iimm(head_inst);
					dec_imm_sel = IMM_I;
					case (funct3)
						`F3_ADD:  dec_alu_func = ALU_ADD;
						`F3_SLT:  dec_alu_func = ALU_SLT;
						`F3_SLTU: dec_alu_func = ALU_SLTU;
						`F3_XOR:  dec_alu_func = ALU_XOR;
						`F3_OR:   dec_alu_func = ALU_OR;
						`F3_AND:  dec_alu_func = ALU_AND;
						`F3_SLL: begin
							dec_alu_func = ALU_SLL;
							dec_illegal  = (funct7 != `F7_BASE);
						end
						// srli / srai split on funct7
						default: begin
							dec_alu_func = (funct7 == `F7_ALT) ? ALU_SRA : ALU_SRL;
							dec_illegal  = (funct7 != `F7_BASE) && (funct7 != `F7_ALT);
						end
					endcase
				end
				OP_OP: begin
					dec_src1 = rs1;
					dec_src2 = rs2;
					dec_dest = rd;
					if (funct7 == `F7_MULDIV) begin
						dec_fu = FU_MULT;
						case (funct3)
							`F3_MUL:    dec_alu_func = ALU_MUL;
							`F3_MULH:   dec_alu_func = ALU_MULH;
							`F3_MULHSU: dec_alu_func = ALU_MULHSU;
							`F3_MULHU:  dec_alu_func = ALU_MULHU;
							// div and rem are not implemented
							default:    dec_illegal = 1'b1;
						endcase
					end else if (funct7 == `F7_BASE) begin
						case (funct3)
							`F3_ADD:  dec_alu_func = ALU_ADD;
							`F3_SLL:  dec_alu_func = ALU_SLL;
							`F3_SLT:  dec_alu_func = ALU_SLT;
							`F3_SLTU: dec_alu_func = ALU_SLTU;
							`F3_XOR:  dec_alu_func = ALU_XOR;
							`F3_SR:   dec_alu_func = ALU_SRL;
							`F3_OR:   dec_alu_func = ALU_OR;
							default:  dec_alu_func = ALU_AND;
						endcase
					end else if (funct7 == `F7_ALT && funct3 == `F3_ADD) begin
						dec_alu_func = ALU_SUB;
					end else if (funct7 == `F7_ALT && funct3 == `F3_SR) begin
						dec_alu_func = ALU_SRA;
					end else begin
						dec_illegal = 1'b1;
					end
				end
				OP_SYSTEM: begin
					// only wfi and register csr forms
					if (head_inst == `RV32_WFI)
						dec_halt = 1'b1;
					else if (funct3 inside {`F3_CSRRW, `F3_CSRRS, `F3_CSRRC})
						dec_csr_op = 1'b1;
					else
						dec_illegal = 1'b1;
				end
				default: dec_illegal = 1'b1;
			endcase

			// misaligned fetch address
			if (head_pc[1:0] != 2'b00)
				dec_illegal = 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: inst_queue.sv
//////////////////////////////////////////////////
// instruction queue
// circular fifo of words and pcs, head exposed
//////////////////////////////////////////////////

`default_nettype none

module inst_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  wire logic                     clock,
	input  wire logic                     rst_n,
	input  wire logic                     flush,
	input  wire logic                     in_valid,
	input  wire logic [decode_pkg::xlen-1:0] in_inst,
	input  wire logic [decode_pkg::xlen-1:0] in_pc,
	output logic                          in_ready,
	input  wire logic                     take,
	output logic                          head_valid,
	output logic [decode_pkg::xlen-1:0]   head_inst,
	output logic [decode_pkg::xlen-1:0]   head_pc
);
	import decode_pkg::*;

	localparam int idx_w = $clog2(QUEUE_DEPTH);

	// word and pc storage
	logic [xlen-1:0] inst_mem [QUEUE_DEPTH];
	logic [xlen-1:0] pc_mem [QUEUE_DEPTH];

	// extra msb tells full from empty
	logic [idx_w:0] wr_ptr;
	logic [idx_w:0] rd_ptr;
	logic [idx_w:0] fill;
	logic           full;
	logic           empty;
	logic           push;
	logic           pop;

	assign fill  = wr_ptr - rd_ptr;
	assign empty = (wr_ptr == rd_ptr);
	// same index after a different number of wraps
	assign full  = (wr_ptr[idx_w] != rd_ptr[idx_w]) &&
		(wr_ptr[idx_w-1:0] == rd_ptr[idx_w-1:0]);

	assign in_ready   = !full;
	assign head_valid = !empty;
	assign head_inst  = inst_mem[rd_ptr[idx_w-1:0]];
	assign head_pc    = pc_mem[rd_ptr[idx_w-1:0]];

	assign push = in_valid && in_ready;
	assign pop  = head_valid && take;

	always_ff @(posedge clock) begin
		if (push) begin
			inst_mem[wr_ptr[idx_w-1:0]] <= in_inst;
			pc_mem[wr_ptr[idx_w-1:0]]   <= in_pc;
		end
	end

	// flush wins over push and pop
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// overflow or underflow shows up as an out-of-range fill level
	a_fill_range: assert property (@(posedge clock) disable iff (!rst_n)
		fill <= QUEUE_DEPTH);

endmodule

`default_nettype wire

// File: decode_pkg.sv
//////////////////////////////////////////////////
// decode package
// widths, unit, function and opcode encodings
// shared by the rv32im decode stage
//////////////////////////////////////////////////

`default_nettype none

package decode_pkg;

	// data and pc width
	localparam int xlen = 32;

	// architectural register index
	typedef logic [4:0] reg_idx_t;

	// target functional unit
	typedef enum logic [1:0] {
		// integer alu, also lui/auipc
		FU_ALU    = 2'd0,
		// m extension multiplier
		FU_MULT   = 2'd1,
		// conditional branches and jumps
		FU_BRANCH = 2'd2,
		// loads and stores
		FU_MEM    = 2'd3
	} fu_type_e;

	// alu / multiplier function
	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_SLT    = 4'd2,
		ALU_SLTU   = 4'd3,
		ALU_AND    = 4'd4,
		ALU_OR     = 4'd5,
		ALU_XOR    = 4'd6,
		ALU_SLL    = 4'd7,
		ALU_SRL    = 4'd8,
		ALU_SRA    = 4'd9,
		// low 32 bits of product
		ALU_MUL    = 4'd10,
		// high half, signed x signed
		ALU_MULH   = 4'd11,
		// high half, signed x unsigned
		ALU_MULHSU = 4'd12,
		// high half, unsigned x unsigned
		ALU_MULHU  = 4'd13
	} alu_func_e;

	// where the immediate came from
	typedef enum logic [2:0] {
		// no immediate, imm is zero
		IMM_NONE = 3'd0,
		IMM_I    = 3'd1,
		IMM_S    = 3'd2,
		IMM_B    = 3'd3,
		IMM_U    = 3'd4,
		IMM_J    = 3'd5
	} imm_sel_e;

	// rv32 major opcodes, inst[6:0]
	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111,
		OP_BRANCH = 7'b1100011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		// register-immediate alu ops
		OP_OP_IMM = 7'b0010011,
		// register-register alu and m ext
		OP_OP     = 7'b0110011,
		// csr access, wfi, ecall
		OP_SYSTEM = 7'b1110011
	} opcode_e;

endpackage

`default_nettype wire

// File: rv32_fields.svh
//////////////////////////////////////////////////
// rv32 instruction fields
// funct3/funct7 codes and immediate extraction
//////////////////////////////////////////////////

`ifndef RV32_FIELDS_SVH
`define RV32_FIELDS_SVH

// funct7 variants for op / op-imm shifts
`define F7_BASE    7'b0000000
`define F7_ALT     7'b0100000
`define F7_MULDIV  7'b0000001

// alu funct3
`define F3_ADD     3'b000
`define F3_SLL     3'b001
`define F3_SLT     3'b010
`define F3_SLTU    3'b011
`define F3_XOR     3'b100
`define F3_SR      3'b101
`define F3_OR      3'b110
`define F3_AND     3'b111

// m extension funct3, div/rem not supported
`define F3_MUL     3'b000
`define F3_MULH    3'b001
`define F3_MULHSU  3'b010
`define F3_MULHU   3'b011

// branch funct3
`define F3_BEQ     3'b000
`define F3_BNE     3'b001
`define F3_BLT     3'b100
`define F3_BGE     3'b101
`define F3_BLTU    3'b110
`define F3_BGEU    3'b111

// load / store widths
`define F3_LB      3'b000
`define F3_LH      3'b001
`define F3_LW      3'b010
`define F3_LBU     3'b100
`define F3_LHU     3'b101

// csr register forms only
`define F3_CSRRW   3'b001
`define F3_CSRRS   3'b010
`define F3_CSRRC   3'b011

// wfi is one fixed word
`define RV32_WFI   32'h10500073

// sign-extended immediates per format
`define RV32_signext_Iimm(inst) {{20{inst[31]}}, inst[31:20]}
`define RV32_signext_Simm(inst) {{20{inst[31]}}, inst[31:25], inst[11:7]}
`define RV32_signext_Bimm(inst) {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}
`define RV32_signext_Uimm(inst) {inst[31:12], 12'b0}
`define RV32_signext_Jimm(inst) {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}

`endif
